/* dv/fetch_mem_model.sv */
`timescale 1ns/1ns

module fetch_mem_model #(
    parameter int unsigned num_tags = 15,
    parameter int seed_value = 1
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_en,
    input  fetch_pkg::addr_t    mem_addr,
    output fetch_pkg::mem_tag_t mem_tag,
    output fetch_pkg::mem_tag_t mem_data_tag,
    output fetch_pkg::block_t   mem_data,
    output int                  busy_count,
    output int                  protocol_errors
);

    integer seed;
    logic accept_ok;
    logic [num_tags:1] busy;
    fetch_pkg::addr_t tag_addr [1:num_tags];
    logic [3:0] wait_cnt [1:num_tags];
    // accepted requests per block in the low 8 KB
    int req_count [0:1023];

    initial begin
        seed = seed_value;
        // quiet bus from time zero
        busy = '0;
        accept_ok = 1'b0;
        mem_data_tag = '0;
        mem_data = '0;
        for (int i = 0; i < 1024; i++) begin
            req_count[i] = 0;
        end
    end

    // memory image computed from the address
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t a);
        return (a ^ 32'h5a5a_0000) + a / 4;
    endfunction

    assign busy_count = $countones(busy);

    // same-cycle answer with the lowest free tag when this cycle's roll accepts
    always_comb begin
        mem_tag = '0;
        for (int t = num_tags; t >= 1; t--) begin
            if (mem_en && accept_ok && !busy[t]) begin
                mem_tag = fetch_pkg::mem_tag_t'(t);
            end
        end
    end

    always @(posedge clock) begin
        logic picked;
        logic dup;
        int errs;
        if (reset) begin
            busy <= '0;
            accept_ok <= 1'b0;
            mem_data_tag <= '0;
            mem_data <= '0;
            protocol_errors <= 0;
        end else begin
            errs = 0;
            picked = 1'b0;
            // roughly one refusal in four
            accept_ok <= ({$random(seed)} % 4) != 0;
            mem_data_tag <= '0;
            // count down and return the lowest ready tag so order follows latency
            for (int t = 1; t <= num_tags; t++) begin
                if (busy[t] && wait_cnt[t] != 0) begin
                    wait_cnt[t] <= wait_cnt[t] - 4'd1;
                end
                if (busy[t] && wait_cnt[t] == 0 && t != mem_data_tag && !picked) begin
                    picked = 1'b1;
                    mem_data_tag <= fetch_pkg::mem_tag_t'(t);
                    mem_data <= {word_at(tag_addr[t] + 4), word_at(tag_addr[t])};
                end
            end
            // tag free once its return has been on the bus
            if (mem_data_tag != '0) begin
                busy[mem_data_tag] <= 1'b0;
            end
            if (mem_en) begin
                assert (mem_addr[2:0] == 3'b000) else begin
                    $display("request at %0t is not block aligned, mem_addr %h", $time, mem_addr);
                    errs++;
                end
                dup = 1'b0;
                for (int t = 1; t <= num_tags; t++) begin
                    if (busy[t] && tag_addr[t][31:3] == mem_addr[31:3]) begin
                        dup = 1'b1;
                    end
                end
                assert (!dup) else begin
                    $display("block %h requested again at %0t while still outstanding",
                             mem_addr, $time);
                    errs++;
                end
            end
            if (mem_tag != '0) begin
                busy[mem_tag] <= 1'b1;
                tag_addr[mem_tag] <= mem_addr;
                wait_cnt[mem_tag] <= 4'({$random(seed)} % 8);
                req_count[mem_addr[12:3]] <= req_count[mem_addr[12:3]] + 1;
            end
            protocol_errors <= protocol_errors + errs;
        end
    end

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/1ns

module fetch_tb;

    localparam int seed_start = 64088;
    localparam int t2_packets = 150;
    localparam int t3_packets = 100;
    localparam int t4_jumps = 6;
    localparam int t4_packets = 10;
    localparam int t5_packets = 40;
    // test 6 runs about 30 packets in two passes
    localparam int all_packets = 1 + t2_packets + t3_packets + t4_jumps * t4_packets
                                 + t5_packets + 30;
    // worst case per packet with refusals and slow ready plus drain time
    localparam int cycle_limit = all_packets * 30 + 2000;
    localparam fetch_pkg::addr_t reuse_base = 32'h0000_1c00;

    logic clock = 1'b0;
    logic reset;
    logic redirect;
    fetch_pkg::addr_t redirect_pc;
    logic mem_en;
    fetch_pkg::addr_t mem_addr;
    fetch_pkg::mem_tag_t mem_tag;
    fetch_pkg::mem_tag_t mem_data_tag;
    fetch_pkg::block_t mem_data;
    logic out_valid;
    logic out_ready;
    logic [2:0] out_count;
    fetch_pkg::fetch_slot_t [fetch_pkg::fetch_width-1:0] out_insts;
    int busy_count;
    int protocol_errors;

    integer seed = seed_start;
    int cycles = 0;
    int errors = 0;
    int transfers = 0;
    int start_errors;
    int snapshot [0:5];
    fetch_pkg::addr_t exp_pc = '0;
    fetch_pkg::addr_t jump_pc;
    // copy of a packet that was not taken
    logic held = 1'b0;
    logic [2:0] held_count;
    fetch_pkg::fetch_slot_t [fetch_pkg::fetch_width-1:0] held_insts;

    always #4 clock = ~clock;

    fetch_top #(
        .prefetch_distance (4),
        .num_mem_tags      (15),
        .cache_sets        (16)
    ) dut0 (
        .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_en(mem_en), .mem_addr(mem_addr), .mem_tag(mem_tag),
        .mem_data_tag(mem_data_tag), .mem_data(mem_data), .out_valid(out_valid),
        .out_ready(out_ready), .out_count(out_count), .out_insts(out_insts)
    );

    fetch_mem_model #(.num_tags(15), .seed_value(seed_start)) mem0 (
        .clock(clock), .reset(reset), .mem_en(mem_en), .mem_addr(mem_addr),
        .mem_tag(mem_tag), .mem_data_tag(mem_data_tag), .mem_data(mem_data),
        .busy_count(busy_count), .protocol_errors(protocol_errors)
    );

    // expected instruction word at a byte address
    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
        return (a ^ 32'h5a5a_0000) + a / 4;
    endfunction

    task automatic check_packet();
        fetch_pkg::addr_t pc;
        assert (out_count >= 1 && out_count <= fetch_pkg::fetch_width) else begin
            $display("error at %0t: out_count = %0d, expected 1 to 4", $time, out_count);
            errors++;
        end
        for (int s = 0; s < fetch_pkg::fetch_width; s++) begin
            pc = exp_pc + 4 * s;
            if (s < out_count) begin
                assert (out_insts[s].pc == pc) else begin
                    $display("error at %0t: out_insts[%0d].pc = %h, expected %h",
                             $time, s, out_insts[s].pc, pc);
                    errors++;
                end
                assert (out_insts[s].inst == mem_word(pc)) else begin
                    $display("error at %0t: out_insts[%0d].inst = %h, expected %h",
                             $time, s, out_insts[s].inst, mem_word(pc));
                    errors++;
                end
            end else begin
                assert (out_insts[s] == '0) else begin
                    $display("error at %0t: out_insts[%0d] = %h, expected 0",
                             $time, s, out_insts[s]);
                    errors++;
                end
            end
        end
        exp_pc = exp_pc + 4 * out_count;
        transfers++;
    endtask

    // sample at the falling edge half a cycle away from any change
    always @(negedge clock) begin
        if (held) begin
            assert (out_valid && out_count == held_count && out_insts == held_insts) else begin
                $display("packet at %0t changed while it waited for out_ready", $time);
                errors++;
            end
        end
        held = out_valid && !out_ready && !redirect && !reset;
        held_count = out_count;
        held_insts = out_insts;
        if (reset) begin
            exp_pc = '0;
        end else if (redirect) begin
            // squashed packet is not a transfer
            exp_pc = redirect_pc;
        end else if (out_valid && out_ready) begin
            check_packet();
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // drive out_ready until n more packets have moved
    task automatic run_packets(input int n, input bit random_ready);
        int target;
        target = transfers + n;
        while (transfers < target) begin
            @(posedge clock);
            #1;
            out_ready = random_ready ? ({$random(seed)} % 3) != 0 : 1'b1;
        end
    endtask

    task automatic run_until(input fetch_pkg::addr_t last_pc);
        while (exp_pc < last_pc) begin
            @(posedge clock);
            #1;
            out_ready = 1'b1;
        end
    endtask

    task automatic jump_to(input fetch_pkg::addr_t pc);
        @(posedge clock);
        #1;
        redirect = 1'b1;
        redirect_pc = pc;
        @(posedge clock);
        #1;
        redirect = 1'b0;
    endtask

    // stall decode until no request is pending or outstanding
    task automatic drain_memory();
        out_ready = 1'b0;
        @(posedge clock);
        #1;
        while (busy_count != 0 || mem_en) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        reset = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        out_ready = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        start_errors = errors;
        run_packets(1, 1'b0);
        $display("test 1 first packet from pc 0: %0d errors", errors - start_errors);

        start_errors = errors;
        run_packets(t2_packets, 1'b0);
        $display("test 2 sequential stream: %0d errors", errors - start_errors);

        start_errors = errors;
        run_packets(t3_packets, 1'b1);
        $display("test 3 random out_ready: %0d errors", errors - start_errors);

        start_errors = errors;
        for (int i = 0; i < t4_jumps; i++) begin
            jump_pc = {$random(seed)} % 4096;
            jump_pc[1:0] = 2'b00;
            // every other target is an odd word
            jump_pc[2] = i % 2;
            jump_to(jump_pc);
            run_packets(t4_packets, 1'b1);
        end
        $display("test 4 redirects: %0d errors", errors - start_errors);

        start_errors = errors;
        jump_to(32'h0000_1800);
        run_packets(t5_packets, 1'b1);
        $display("test 5 memory protocol: %0d errors, %0d protocol errors",
                 errors - start_errors, protocol_errors);

        start_errors = errors;
        drain_memory();
        jump_to(reuse_base);
        run_until(reuse_base + 48);
        drain_memory();
        for (int b = 0; b < 6; b++) begin
            snapshot[b] = mem0.req_count[int'(reuse_base[12:3]) + b];
        end
        // second pass over the same six blocks
        jump_to(reuse_base);
        run_until(reuse_base + 48);
        for (int b = 0; b < 6; b++) begin
            assert (mem0.req_count[int'(reuse_base[12:3]) + b] == snapshot[b]) else begin
                $display("error at %0t: req_count of block %h = %0d, expected %0d",
                         $time, reuse_base + 8 * b,
                         mem0.req_count[int'(reuse_base[12:3]) + b], snapshot[b]);
                errors++;
            end
        end
        $display("test 6 refetch from cache: %0d errors", errors - start_errors);

        $display("done: %0d packets, %0d errors, %0d memory protocol errors",
                 transfers, errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* hw/fetch_icache.sv */
`timescale 1ns/1ns

module fetch_icache #(
    parameter int unsigned prefetch_distance = 4,
    parameter int unsigned cache_sets = 16
) (
    input  logic                              clock,
    input  logic                              reset,

    // window read side
    input  fetch_pkg::addr_t                  fetch_pc,

    // fill port from the miss unit
    input  logic                              fill_en,
    input  fetch_pkg::addr_t                  fill_addr,
    input  fetch_pkg::block_t                 fill_data,

    // one hit flag and block per window slot
    output logic [prefetch_distance-1:0]      block_valid,
    output fetch_pkg::block_t [prefetch_distance-1:0] block_data
);

    // set index sits right above the block offset
    localparam int unsigned index_bits = $clog2(cache_sets);
    localparam int unsigned index_lsb  = fetch_pkg::block_offset_bits;
    localparam int unsigned tag_lsb    = index_lsb + index_bits;
    localparam int unsigned tag_bits   = $bits(fetch_pkg::addr_t) - tag_lsb;

    fetch_pkg::block_t      set_data [cache_sets];
    logic [tag_bits-1:0]    set_tag  [cache_sets];
    logic [cache_sets-1:0]  set_valid;

    logic [index_bits-1:0]  fill_index;

    assign fill_index = fill_addr[index_lsb +: index_bits];

    // valid bits, kept across redirects
    always_ff @(posedge clock) begin
        if (reset) begin
            set_valid <= '0;
        end else if (fill_en) begin
            set_valid[fill_index] <= 1'b1;
        end
    end

    // block store and tags
    always_ff @(posedge clock) begin
        if (fill_en) begin
            set_data[fill_index] <= fill_data;
            set_tag[fill_index]  <= fill_addr[tag_lsb +: tag_bits];
        end
    end

    // one combinational read port per window slot
    always_comb begin
        fetch_pkg::addr_t      rd_addr;
        logic [index_bits-1:0] rd_index;
        for (int unsigned k = 0; k < prefetch_distance; k++) begin
            rd_addr  = fetch_pkg::window_block_addr(fetch_pc, k);
            rd_index = rd_addr[index_lsb +: index_bits];
            // hit needs the set valid and the tag to match
            block_valid[k] = set_valid[rd_index] &&
                             (set_tag[rd_index] == rd_addr[tag_lsb +: tag_bits]);
            block_data[k]  = set_data[rd_index];
        end
    end

endmodule

/* hw/fetch_miss_unit.sv */
`timescale 1ns/1ns

module fetch_miss_unit #(
    parameter int unsigned prefetch_distance = 4,
    parameter int unsigned num_mem_tags = 15
) (
    input  logic                      clock,
    input  logic                      reset,

    // window position and cache state
    input  fetch_pkg::addr_t          fetch_pc,
    input  logic [prefetch_distance-1:0] block_valid,

    // memory request side, answered in the same cycle
    output logic                      mem_en,
    output fetch_pkg::addr_t          mem_addr,
    input  fetch_pkg::mem_tag_t       mem_tag,

    // memory return side
    input  fetch_pkg::mem_tag_t       mem_data_tag,
    input  fetch_pkg::block_t         mem_data,

    // fill port into the cache
    output logic                      fill_en,
    output fetch_pkg::addr_t          fill_addr,
    output fetch_pkg::block_t         fill_data
);

    // miss table, indexed by tag, entry 0 unused
    fetch_pkg::addr_t          mshr_addr [1:num_mem_tags];
    logic [num_mem_tags:1]     mshr_valid;

    logic accept;
    logic return_hit;

    // pick the lowest window slot that is neither cached nor outstanding
    always_comb begin
        fetch_pkg::addr_t win_addr;
        logic             in_table;
        mem_en   = 1'b0;
        mem_addr = '0;
        for (int unsigned k = 0; k < prefetch_distance; k++) begin
            win_addr = fetch_pkg::window_block_addr(fetch_pc, k);
            in_table = 1'b0;
            // compare block addresses only
            for (int unsigned j = 1; j <= num_mem_tags; j++) begin
                if (mshr_valid[j] &&
                    mshr_addr[j][31:fetch_pkg::block_offset_bits] ==
                    win_addr[31:fetch_pkg::block_offset_bits]) begin
                    in_table = 1'b1;
                end
            end
            if (!mem_en && !block_valid[k] && !in_table) begin
                mem_en   = 1'b1;
                mem_addr = win_addr;
            end
        end
    end

    // nonzero tag in range means memory took the request
    assign accept = mem_en && (mem_tag != '0) && (mem_tag <= num_mem_tags);

    // return for a tag we are tracking
    assign return_hit = (mem_data_tag != '0) && (mem_data_tag <= num_mem_tags) &&
                        mshr_valid[mem_data_tag];

    // fill goes straight to the cache, lands at the next edge
    assign fill_en   = return_hit;
    assign fill_addr = return_hit ? mshr_addr[mem_data_tag] : '0;
    assign fill_data = mem_data;

    // valid bits
    // free on return first, so a tag reused in the same cycle stays valid
    always_ff @(posedge clock) begin
        if (reset) begin
            mshr_valid <= '0;
        end else begin
            if (return_hit) begin
                mshr_valid[mem_data_tag] <= 1'b0;
            end
            if (accept) begin
                mshr_valid[mem_tag] <= 1'b1;
            end
        end
    end

    // recorded block address per tag
    always_ff @(posedge clock) begin
        if (accept) begin
            mshr_addr[mem_tag] <= mem_addr;
        end
    end

endmodule

/* hw/fetch_packer.sv */
`timescale 1ns/1ns

module fetch_packer #(
    parameter int unsigned prefetch_distance = 4
) (
    input  logic                              clock,
    input  logic                              reset,

    // squash redirect
    input  logic                              redirect,
    input  fetch_pkg::addr_t                  redirect_pc,

    // window contents from the cache
    input  logic [prefetch_distance-1:0]      block_valid,
    input  fetch_pkg::block_t [prefetch_distance-1:0] block_data,

    // current fetch position
    output fetch_pkg::addr_t                  fetch_pc,

    // packet to decode
    output logic                              out_valid,
    input  logic                              out_ready,
    output logic [2:0]                        out_count,
    output fetch_pkg::fetch_slot_t [fetch_pkg::fetch_width-1:0] out_insts
);

    logic [3:0]                                           avail;
    logic [2:0]                                           next_count;
    fetch_pkg::fetch_slot_t [fetch_pkg::fetch_width-1:0]  next_insts;
    fetch_pkg::addr_t                                     next_pc;
    logic                                                 load;

    // instructions in the leading run of cached blocks
    always_comb begin
        logic run_open;
        avail    = '0;
        run_open = 1'b1;
        for (int unsigned b = 0; b < fetch_pkg::assemble_blocks; b++) begin
            if (run_open && block_valid[b]) begin
                // odd-word start uses only the upper word of block 0
                if (b == 0 && fetch_pc[2]) begin
                    avail = avail + 4'd1;
                end else begin
                    avail = avail + 4'd2;
                end
            end else begin
                run_open = 1'b0;
            end
        end
        // cap at packet width
        if (avail > 4'(fetch_pkg::fetch_width)) begin
            next_count = 3'(fetch_pkg::fetch_width);
        end else begin
            next_count = avail[2:0];
        end
    end

    // fill slots with sequential words and pcs, zero past the count
    always_comb begin
        int unsigned word;
        for (int unsigned s = 0; s < fetch_pkg::fetch_width; s++) begin
            // word position counted from the start of window block 0
            word = s + fetch_pc[2];
            next_insts[s] = '0;
            if (s < next_count) begin
                next_insts[s].pc   = fetch_pc + fetch_pkg::addr_t'(4 * s);
                next_insts[s].inst = block_data[word / 2][word % 2];
            end
        end
    end

    assign next_pc = fetch_pc + {27'd0, next_count, 2'b00};

    // load when something is ready and the register is free or draining
    assign load = !redirect && (next_count != '0) && (!out_valid || out_ready);

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc  <= '0;
            out_valid <= 1'b0;
            out_count <= '0;
            out_insts <= '0;
        end else if (redirect) begin
            // drop the held packet, keep word alignment
            fetch_pc  <= {redirect_pc[31:2], 2'b00};
            out_valid <= 1'b0;
            out_count <= '0;
            out_insts <= '0;
        end else if (load) begin
            fetch_pc  <= next_pc;
            out_valid <= 1'b1;
            out_count <= next_count;
            out_insts <= next_insts;
        end else if (out_ready) begin
            // drained with nothing new to load
            out_valid <= 1'b0;
            out_count <= '0;
            out_insts <= '0;
        end
    end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // byte address, one 32-bit word
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // one memory block
    // word 0 sits at the block address, word 1 at block address + 4
    typedef inst_t [1:0] block_t;

    // memory transaction tag
    // zero means no transaction: request refused, or no return this cycle
    typedef logic [3:0] mem_tag_t;

    // one slot of a fetch packet
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_slot_t;

    // bits below this are dropped to form a block address
    localparam int unsigned block_offset_bits = 3;

    // most instructions in one packet, so the count needs 3 bits
    localparam int unsigned fetch_width = 4;

    // window blocks the packer may draw from
    // four words starting at an odd word span three blocks
    localparam int unsigned assemble_blocks = 3;

    // block address of window slot k relative to a fetch pc
    // shared by the miss unit and the cache so both see the same window
    function automatic addr_t window_block_addr(
        input addr_t       pc,
        input int unsigned k
    );
        addr_t base;
        addr_t step;
        base = {pc[$bits(addr_t)-1:block_offset_bits], {block_offset_bits{1'b0}}};
        step = addr_t'(k) << block_offset_bits;
        return base + step;
    endfunction

endpackage

/* hw/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top #(
    parameter int unsigned prefetch_distance = 4,
    parameter int unsigned num_mem_tags = 15,
    parameter int unsigned cache_sets = 16
) (
    input  logic                        clock,
    input  logic                        reset,

    // squash redirect from the back end
    input  logic                        redirect,
    input  fetch_pkg::addr_t            redirect_pc,

    // tagged memory interface
    output logic                        mem_en,
    output fetch_pkg::addr_t            mem_addr,
    input  fetch_pkg::mem_tag_t         mem_tag,
    input  fetch_pkg::mem_tag_t         mem_data_tag,
    input  fetch_pkg::block_t           mem_data,

    // packet to decode
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [2:0]                  out_count,
    output fetch_pkg::fetch_slot_t [fetch_pkg::fetch_width-1:0] out_insts
);

    fetch_pkg::addr_t                               fetch_pc;
    logic [prefetch_distance-1:0]                   block_valid;
    fetch_pkg::block_t [prefetch_distance-1:0]      block_data;
    logic                                           fill_en;
    fetch_pkg::addr_t                               fill_addr;
    fetch_pkg::block_t                              fill_data;

    // requests missing window blocks, turns returns into fills
    fetch_miss_unit #(
        .prefetch_distance (prefetch_distance),
        .num_mem_tags      (num_mem_tags)
    ) miss_unit0 (
        .clock        (clock),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .block_valid  (block_valid),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .mem_tag      (mem_tag),
        .mem_data_tag (mem_data_tag),
        .mem_data     (mem_data),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

    // block store, read across the whole window
    fetch_icache #(
        .prefetch_distance (prefetch_distance),
        .cache_sets        (cache_sets)
    ) icache0 (
        .clock       (clock),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .block_valid (block_valid),
        .block_data  (block_data)
    );

    // owns fetch_pc and the output register
    fetch_packer #(
        .prefetch_distance (prefetch_distance)
    ) packer0 (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .block_valid (block_valid),
        .block_data  (block_data),
        .fetch_pc    (fetch_pc),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_count   (out_count),
        .out_insts   (out_insts)
    );

endmodule

/* list.f */
hw/fetch_pkg.sv
hw/fetch_miss_unit.sv
hw/fetch_icache.sv
hw/fetch_packer.sv
hw/fetch_top.sv
dv/fetch_mem_model.sv
dv/fetch_tb.sv
